// ==== common/leaf_defs.svh ====
`ifndef LEAF_DEFS_SVH
`define LEAF_DEFS_SVH

// packet layout on the tree side.
`define PACKET_BITS   49
`define PAYLOAD_BITS  32
`define LEAF_BITS     5
`define PORT_BITS     4
`define ADDR_BITS     7

// port counts seen by the kernel.
`define NUM_IN_PORTS  3
`define NUM_OUT_PORTS 7

`define FIFO_DEPTH    4   // entries per input queue.

`define THIS_LEAF     5'd3

`endif

// ==== common/bft_pkg.sv ====
`default_nettype none
`include "leaf_defs.svh"

package bft_pkg;

    typedef logic [`LEAF_BITS-1:0] leaf_id_t;
    typedef logic [`PORT_BITS-1:0] port_id_t;
    typedef logic [`ADDR_BITS-1:0] addr_t;

    // valid sits in the top bit, payload in the low word.
    typedef struct packed {
        logic                     valid;
        leaf_id_t                 leaf;
        port_id_t                 port;
        addr_t                    addr;
        logic [`PAYLOAD_BITS-1:0] payload;
    } packet_t;

endpackage

`default_nettype wire

// ==== common/user_pkg.sv ====
`default_nettype none
`include "leaf_defs.svh"

package user_pkg;

    typedef logic [`PAYLOAD_BITS-1:0] word_t;

    // one triple in, seven results out.
    typedef enum logic [1:0] {
        IDLE,
        CALC,
        EMIT
    } kernel_state_t;

endpackage

`default_nettype wire

// ==== leaf_interface/packet_demux.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "leaf_defs.svh"

module packet_demux
    import bft_pkg::*, user_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire packet_t               din,
    input  wire [`NUM_IN_PORTS-1:0]    full,
    output logic [`NUM_IN_PORTS-1:0]   wr_en,
    output word_t                      wr_data,
    output logic                       cfg_we,
    output addr_t                      cfg_sel,
    output leaf_id_t                   cfg_leaf,
    output port_id_t                   cfg_port
);

    packet_t pkt_q;
    logic    pkt_vld_q;
    logic    for_us;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_vld_q <= 1'b0;
        end else begin
            pkt_vld_q <= din.valid;
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= din;
    end

    assign for_us = pkt_vld_q && (pkt_q.leaf == `THIS_LEAF);

    // data ports 1..3 map onto queues 0..2.
    always_comb begin
        wr_en = '0;
        for (int i = 0; i < `NUM_IN_PORTS; i++) begin
            if (for_us && (pkt_q.port == port_id_t'(i + 1))) begin
                wr_en[i] = !full[i]; // a full queue loses the word.
            end
        end
    end

    assign wr_data = pkt_q.payload;

    // port 0 carries table writes, only entries 1..7 exist.
    assign cfg_we   = for_us && (pkt_q.port == '0) && (pkt_q.addr != '0) &&
                      (pkt_q.addr <= addr_t'(`NUM_OUT_PORTS));
    assign cfg_sel  = pkt_q.addr;
    assign cfg_leaf = pkt_q.payload[`PORT_BITS +: `LEAF_BITS];
    assign cfg_port = pkt_q.payload[`PORT_BITS-1:0];

endmodule

`default_nettype wire

// ==== leaf_interface/port_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module port_fifo
    import user_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        wr_en,
    input  wire word_t wr_data,
    input  wire        ack,
    output logic       full,
    output word_t      dout,
    output logic       vld
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    word_t               mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [CNT_BITS-1:0] count_q;
    logic                push;
    logic                pop;

    assign full = (count_q == CNT_BITS'(DEPTH));
    assign vld  = (count_q != '0);
    assign dout = mem[rd_ptr_q];

    assign push = wr_en && !full;
    assign pop  = ack && vld;   // an ack with nothing shown is ignored.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== leaf_interface/out_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "leaf_defs.svh"

module out_arbiter
    import bft_pkg::*, user_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  resend,
    input  wire word_t    [`NUM_OUT_PORTS-1:0]   din,
    input  wire           [`NUM_OUT_PORTS-1:0]   vld,
    input  wire leaf_id_t [`NUM_OUT_PORTS-1:0]   dest_leaf,
    input  wire port_id_t [`NUM_OUT_PORTS-1:0]   dest_port,
    output logic          [`NUM_OUT_PORTS-1:0]   ack,
    output packet_t                              dout
);

    localparam int SEL_BITS = $clog2(`NUM_OUT_PORTS);

    logic [SEL_BITS-1:0] last_q;
    logic [SEL_BITS-1:0] grant_idx;
    logic                grant;
    addr_t               seq_q [`NUM_OUT_PORTS];
    packet_t             pkt_q;

    // search starts one past the last port served.
    always_comb begin
        int cand;
        grant     = 1'b0;
        grant_idx = '0;
        cand      = 0;
        for (int i = 0; i < `NUM_OUT_PORTS; i++) begin
            cand = (int'(last_q) + 1 + i) % `NUM_OUT_PORTS;
            if (!grant && !resend && vld[cand]) begin
                grant     = 1'b1;
                grant_idx = cand[SEL_BITS-1:0];
            end
        end
    end

    always_comb begin
        ack = '0;
        if (grant) begin
            ack[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= SEL_BITS'(`NUM_OUT_PORTS - 1); // so port 1 is searched first.
            pkt_q  <= '0;
        end else begin
            pkt_q <= '0;
            if (grant) begin
                last_q        <= grant_idx;
                pkt_q.valid   <= 1'b1;
                pkt_q.leaf    <= dest_leaf[grant_idx];
                pkt_q.port    <= dest_port[grant_idx];
                pkt_q.addr    <= seq_q[grant_idx];
                pkt_q.payload <= din[grant_idx];
            end
        end
    end

    // per port sequence numbers, wrapping at 128.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_OUT_PORTS; i++) begin
                seq_q[i] <= '0;
            end
        end else if (grant) begin
            seq_q[grant_idx] <= seq_q[grant_idx] + 1'b1;
        end
    end

    assign dout = resend ? '0 : pkt_q; // the tree sees silence during resend.

endmodule

`default_nettype wire

// ==== leaf_interface/leaf_interface.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "leaf_defs.svh"

module leaf_interface
    import bft_pkg::*, user_pkg::*;
(
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire packet_t                       din_leaf_bft2interface,
    output packet_t                            dout_leaf_interface2bft,
    input  wire                                resend,
    input  wire                                ap_start,
    output logic                               run,
    output word_t [`NUM_IN_PORTS-1:0]          dout_leaf_interface2user,
    output logic  [`NUM_IN_PORTS-1:0]          vld_interface2user,
    input  wire   [`NUM_IN_PORTS-1:0]          ack_user2interface,
    input  wire word_t [`NUM_OUT_PORTS-1:0]    din_leaf_user2interface,
    input  wire   [`NUM_OUT_PORTS-1:0]         vld_user2interface,
    output logic  [`NUM_OUT_PORTS-1:0]         ack_interface2user
);

    logic [`NUM_IN_PORTS-1:0]        wr_en;
    logic [`NUM_IN_PORTS-1:0]        full;
    word_t                           wr_data;
    logic                            cfg_we;
    addr_t                           cfg_sel;
    leaf_id_t                        cfg_leaf;
    port_id_t                        cfg_port;
    leaf_id_t [`NUM_OUT_PORTS-1:0]   dest_leaf_q;
    port_id_t [`NUM_OUT_PORTS-1:0]   dest_port_q;

    packet_demux i_packet_demux (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din_leaf_bft2interface),
        .full     (full),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .cfg_we   (cfg_we),
        .cfg_sel  (cfg_sel),
        .cfg_leaf (cfg_leaf),
        .cfg_port (cfg_port)
    );

    for (genvar i = 0; i < `NUM_IN_PORTS; i++) begin : g_in_port
        port_fifo #(
            .DEPTH (`FIFO_DEPTH)
        ) i_port_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data),
            .ack     (ack_user2interface[i]),
            .full    (full[i]),
            .dout    (dout_leaf_interface2user[i]),
            .vld     (vld_interface2user[i])
        );
    end

    // destination table, entry i serves output port i+1.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_leaf_q <= '0;
            dest_port_q <= '0;
        end else if (cfg_we) begin
            for (int i = 0; i < `NUM_OUT_PORTS; i++) begin
                if (cfg_sel == addr_t'(i + 1)) begin
                    dest_leaf_q[i] <= cfg_leaf;
                    dest_port_q[i] <= cfg_port;
                end
            end
        end
    end

    // run stays up until the next reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (ap_start) begin
            run <= 1'b1;
        end
    end

    out_arbiter i_out_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .resend    (resend),
        .din       (din_leaf_user2interface),
        .vld       (vld_user2interface),
        .dest_leaf (dest_leaf_q),
        .dest_port (dest_port_q),
        .ack       (ack_interface2user),
        .dout      (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

// ==== user_kernel/user_kernel.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "leaf_defs.svh"

module user_kernel
    import user_pkg::*;
(
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                run,
    input  wire word_t [`NUM_IN_PORTS-1:0]     dout_leaf_interface2user,
    input  wire   [`NUM_IN_PORTS-1:0]          vld_interface2user,
    output logic  [`NUM_IN_PORTS-1:0]          ack_user2interface,
    output word_t [`NUM_OUT_PORTS-1:0]         din_leaf_user2interface,
    output logic  [`NUM_OUT_PORTS-1:0]         vld_user2interface,
    input  wire   [`NUM_OUT_PORTS-1:0]         ack_interface2user
);

    kernel_state_t                state_q;
    word_t                        a_q;
    word_t                        b_q;
    word_t                        c_q;
    word_t [`NUM_OUT_PORTS-1:0]   res_q;
    logic  [`NUM_OUT_PORTS-1:0]   pend_q;
    logic  [`NUM_OUT_PORTS-1:0]   pend_next;
    logic                         take;

    // all three words are consumed in the same cycle.
    assign take = (state_q == IDLE) && run && (&vld_interface2user);
    assign ack_user2interface = {`NUM_IN_PORTS{take}};

    assign pend_next = pend_q & ~ack_interface2user;

    assign vld_user2interface      = pend_q;
    assign din_leaf_user2interface = res_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            pend_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (take) begin
                        state_q <= CALC;
                    end
                end
                CALC: begin
                    pend_q  <= '1; // every result goes out together.
                    state_q <= EMIT;
                end
                EMIT: begin
                    pend_q <= pend_next;
                    if (pend_next == '0) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            a_q <= dout_leaf_interface2user[0];
            b_q <= dout_leaf_interface2user[1];
            c_q <= dout_leaf_interface2user[2];
        end
    end

    // sums and differences wrap at 32 bits.
    always_ff @(posedge clk) begin
        if (state_q == CALC) begin
            res_q[0] <= a_q + b_q;
            res_q[1] <= a_q - b_q;
            res_q[2] <= a_q ^ c_q;
            res_q[3] <= b_q + c_q;
            res_q[4] <= a_q & b_q;
            res_q[5] <= a_q | c_q;
            res_q[6] <= a_q + b_q + c_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/leaf_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "leaf_defs.svh"

module leaf_top
    import bft_pkg::*, user_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire packet_t din_leaf_bft2interface,
    output packet_t      dout_leaf_interface2bft,
    input  wire          resend,
    input  wire          ap_start
);

    logic                         run;
    word_t [`NUM_IN_PORTS-1:0]    dout_leaf_interface2user;
    logic  [`NUM_IN_PORTS-1:0]    vld_interface2user;
    logic  [`NUM_IN_PORTS-1:0]    ack_user2interface;
    word_t [`NUM_OUT_PORTS-1:0]   din_leaf_user2interface;
    logic  [`NUM_OUT_PORTS-1:0]   vld_user2interface;
    logic  [`NUM_OUT_PORTS-1:0]   ack_interface2user;

    leaf_interface i_leaf_interface (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .run                      (run),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    user_kernel i_user_kernel (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .run                      (run),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

endmodule

`default_nettype wire

// ==== bench/leaf_tb_tasks.svh ====
// expected result on output port k (1..7) for one input triple.
function automatic word_t model_result(input int k, input word_t a, input word_t b,
                                       input word_t c);
    case (k)
        1: return a + b;
        2: return a - b;
        3: return a ^ c;
        4: return b + c;
        5: return a & b;
        6: return a | c;
        default: return a + b + c;
    endcase
endfunction

// each output port gets its own leaf and port, so both identify it.
function automatic leaf_id_t dest_leaf_of(input int k);
    return leaf_id_t'(16 + k);
endfunction

function automatic port_id_t dest_port_of(input int k);
    return port_id_t'(8 + k);
endfunction

function automatic packet_t make_packet(input leaf_id_t leaf, input port_id_t port,
                                        input addr_t addr, input word_t payload);
    packet_t p;
    p.valid   = 1'b1;
    p.leaf    = leaf;
    p.port    = port;
    p.addr    = addr;
    p.payload = payload;
    return p;
endfunction

task automatic send_packet(input packet_t p);
    @(posedge clk);
    din_pkt <= p;
endtask

task automatic release_bus;
    @(posedge clk);
    din_pkt <= '0;
endtask

// one word each on input ports 1, 2 and 3.
task automatic send_triple(input word_t a, input word_t b, input word_t c);
    send_packet(make_packet(`THIS_LEAF, 4'd1, '0, a));
    send_packet(make_packet(`THIS_LEAF, 4'd2, '0, b));
    send_packet(make_packet(`THIS_LEAF, 4'd3, '0, c));
    exp_a.push_back(a);
    exp_b.push_back(b);
    exp_c.push_back(c);
endtask

task automatic load_table;
    for (int k = 1; k <= `NUM_OUT_PORTS; k++) begin
        send_packet(make_packet(`THIS_LEAF, 4'd0, addr_t'(k),
                                word_t'({dest_leaf_of(k), dest_port_of(k)})));
    end
    release_bus();
endtask

task automatic pulse_start;
    @(posedge clk);
    ap_start <= 1'b1;
    @(posedge clk);
    ap_start <= 1'b0;
endtask

task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
        $display("MISMATCH %s payload: expected %h, actual %h", name, exp, act);
        err_cnt++;
    end
endtask

task automatic compare_leaf(input string name, input leaf_id_t exp, input leaf_id_t act);
    if (exp !== act) begin
        $display("MISMATCH %s leaf: expected %0d, actual %0d", name, exp, act);
        err_cnt++;
    end
endtask

task automatic compare_port(input string name, input port_id_t exp, input port_id_t act);
    if (exp !== act) begin
        $display("MISMATCH %s port: expected %0d, actual %0d", name, exp, act);
        err_cnt++;
    end
endtask

task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
        $display("MISMATCH %s sequence: expected %0d, actual %0d", name, exp, act);
        err_cnt++;
    end
endtask

// waits for n packets, then watches a little longer for extra ones.
task automatic wait_packets(input string name, input int n, input int limit);
    int waited;
    waited = 0;
    while (rx_q.size() < n && waited < limit) begin
        @(posedge clk);
        waited++;
    end
    repeat (10) @(posedge clk);
    if (rx_q.size() != n) begin
        $display("%s: %0d packets came out, %0d were expected", name, rx_q.size(), n);
        err_cnt++;
    end
endtask

// packets of one output port must follow the input order with rising sequence numbers.
task automatic check_outputs(input string name, input int seq_base);
    packet_t got[$];
    for (int k = 1; k <= `NUM_OUT_PORTS; k++) begin
        got.delete();
        foreach (rx_q[i]) begin
            if (rx_q[i].leaf == dest_leaf_of(k) || rx_q[i].port == dest_port_of(k)) begin
                got.push_back(rx_q[i]);
            end
        end
        if (got.size() != exp_a.size()) begin
            $display("%s: output port %0d sent %0d packets instead of %0d",
                     name, k, got.size(), exp_a.size());
            err_cnt++;
        end else begin
            foreach (got[j]) begin
                compare_leaf(name, dest_leaf_of(k), got[j].leaf);
                compare_port(name, dest_port_of(k), got[j].port);
                compare_addr(name, addr_t'(seq_base + j), got[j].addr);
                compare_word(name, model_result(k, exp_a[j], exp_b[j], exp_c[j]),
                             got[j].payload);
            end
        end
    end
endtask

// ==== bench/leaf_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "leaf_defs.svh"

module leaf_tb
    import bft_pkg::*, user_pkg::*;
();

    // cycle budget of each test, summed into the run limit.
    localparam int LEN_CONFIG  = 120;
    localparam int LEN_FILTER  = 120;
    localparam int LEN_GATING  = 160;
    localparam int LEN_RESEND  = 120;
    localparam int LEN_STREAM  = 240;
    localparam int RUN_LIMIT   = LEN_CONFIG + LEN_FILTER + LEN_GATING + LEN_RESEND +
                                 LEN_STREAM + 100;

    logic        clk;
    logic        rst_n;
    logic        resend;
    logic        ap_start;
    packet_t     din_pkt;
    packet_t     dout_pkt;
    packet_t     rx_q[$];
    word_t       exp_a[$];
    word_t       exp_b[$];
    word_t       exp_c[$];
    int          err_cnt;
    int          test_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int unsigned seed_init;

    leaf_top i_leaf_top (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_pkt),
        .dout_leaf_interface2bft (dout_pkt),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    `include "leaf_tb_tasks.svh"

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= RUN_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", RUN_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // outputs settle mid cycle, so the monitor samples on the falling edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (resend && dout_pkt != '0) begin
                $display("output was not silent while resend was high: %h", dout_pkt);
                err_cnt++;
            end
            if (dout_pkt.valid) rx_q.push_back(dout_pkt);
        end
    end

    task automatic reset_dut;
        @(posedge clk);
        rst_n    <= 1'b0;
        din_pkt  <= '0;
        resend   <= 1'b0;
        ap_start <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic start_capture;
        rx_q.delete();
        exp_a.delete();
        exp_b.delete();
        exp_c.delete();
    endtask

    task automatic finish_test(input string name, input int err_start);
        test_cnt++;
        if (err_cnt != err_start) begin
            fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - err_start);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic test_config_single;
        int e0;
        e0 = err_cnt;
        start_capture();
        load_table();
        pulse_start();
        send_triple($urandom, $urandom, $urandom);
        release_bus();
        wait_packets("config_single", 7, 60);
        check_outputs("config_single", 0);
        finish_test("config_single", e0);
    endtask

    task automatic test_filtering;
        int e0;
        e0 = err_cnt;
        start_capture();
        send_packet(make_packet(5'd7, 4'd1, '0, $urandom)); // another leaf.
        for (int p = 5; p < 16; p++) begin
            send_packet(make_packet(`THIS_LEAF, port_id_t'(p), '0, $urandom));
        end
        // table entries that do not exist, aimed at leaf 1 port 1.
        send_packet(make_packet(`THIS_LEAF, 4'd0, 7'd0, 32'h11));
        send_packet(make_packet(`THIS_LEAF, 4'd0, 7'd8, 32'h11));
        release_bus();
        repeat (20) @(posedge clk);
        if (rx_q.size() != 0) begin
            $display("filtering: %0d packets came out of dropped traffic", rx_q.size());
            err_cnt++;
        end
        start_capture();
        send_triple($urandom, $urandom, $urandom);
        release_bus();
        wait_packets("filtering", 7, 60);
        check_outputs("filtering", 1);
        finish_test("filtering", e0);
    endtask

    task automatic test_start_gating;
        int e0;
        e0 = err_cnt;
        reset_dut();
        start_capture();
        load_table();
        send_triple($urandom, $urandom, $urandom);
        release_bus();
        repeat (40) @(posedge clk);
        if (rx_q.size() != 0) begin
            $display("start_gating: the kernel produced output before ap_start");
            err_cnt++;
        end
        pulse_start();
        wait_packets("start_gating", 7, 60);
        check_outputs("start_gating", 0);
        finish_test("start_gating", e0);
    endtask

    task automatic test_resend;
        int e0;
        e0 = err_cnt;
        start_capture();
        @(posedge clk);
        resend <= 1'b1;
        send_triple($urandom, $urandom, $urandom);
        release_bus();
        repeat (20) @(posedge clk);  // results are pending by now.
        if (rx_q.size() != 0) begin
            $display("resend: packets were sent while resend was high");
            err_cnt++;
        end
        @(posedge clk);
        resend <= 1'b0;
        wait_packets("resend", 7, 60);
        check_outputs("resend", 1);
        finish_test("resend", e0);
    endtask

    task automatic test_stream;
        int e0;
        e0 = err_cnt;
        start_capture();
        for (int j = 0; j < 4; j++) begin
            send_triple($urandom, $urandom, $urandom);
        end
        release_bus();
        wait_packets("stream", 28, 150);
        check_outputs("stream", 2);
        finish_test("stream", e0);
    endtask

    initial begin
        rst_n     = 1'b0;
        resend    = 1'b0;
        ap_start  = 1'b0;
        din_pkt   = '0;
        err_cnt   = 0;
        test_cnt  = 0;
        fail_cnt  = 0;
        cycle_cnt = 0;
        seed_init = $urandom(32'h233e);
        reset_dut();
        test_config_single();
        test_filtering();
        test_start_gating();
        test_resend();
        test_stream();
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== leaf.f ====
+incdir+common
+incdir+bench
common/bft_pkg.sv
common/user_pkg.sv
leaf_interface/packet_demux.sv
leaf_interface/port_fifo.sv
leaf_interface/out_arbiter.sv
leaf_interface/leaf_interface.sv
user_kernel/user_kernel.sv
logic/leaf_top.sv
bench/leaf_tb.sv
